//--- design/median3x3.sv
`timescale 1ns/10ps

module median3x3 (
    input  logic              clk,
    input  logic              rst_n,
    input  median_pkg::chan_t p11,
    input  median_pkg::chan_t p12,
    input  median_pkg::chan_t p13,
    input  median_pkg::chan_t p21,
    input  median_pkg::chan_t p22,
    input  median_pkg::chan_t p23,
    input  median_pkg::chan_t p31,
    input  median_pkg::chan_t p32,
    input  median_pkg::chan_t p33,
    output median_pkg::chan_t med
);

    localparam int W = median_pkg::CH_W;

    logic [3*W-1:0] row_srt [3];           // {max, mid, min} per row
    logic [3*W-1:0] row_q   [3];
    logic [3*W-1:0] max_srt;
    logic [3*W-1:0] mid_srt;
    logic [3*W-1:0] min_srt;
    logic [3*W-1:0] fin_srt;

    median_pkg::chan_t min_of_max;
    median_pkg::chan_t mid_of_mid;
    median_pkg::chan_t max_of_min;

    // ------------------------------------------------------------------------
    // Stage 1: sort each row
    // ------------------------------------------------------------------------
    assign row_srt[0] = median_pkg::sort3(p11, p12, p13);
    assign row_srt[1] = median_pkg::sort3(p21, p22, p23);
    assign row_srt[2] = median_pkg::sort3(p31, p32, p33);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                row_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                row_q[i] <= row_srt[i];
            end
        end
    end

    // Stage 2: sort the columns of the row results
    assign max_srt = median_pkg::sort3(row_q[0][3*W-1:2*W], row_q[1][3*W-1:2*W],
                                       row_q[2][3*W-1:2*W]);
    assign mid_srt = median_pkg::sort3(row_q[0][2*W-1:W], row_q[1][2*W-1:W],
                                       row_q[2][2*W-1:W]);
    assign min_srt = median_pkg::sort3(row_q[0][W-1:0], row_q[1][W-1:0],
                                       row_q[2][W-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            min_of_max <= '0;
            mid_of_mid <= '0;
            max_of_min <= '0;
        end else begin
            min_of_max <= max_srt[W-1:0];
            mid_of_mid <= mid_srt[2*W-1:W];
            max_of_min <= min_srt[3*W-1:2*W];
        end
    end

    // Stage 3: median of the three candidates is the window median
    assign fin_srt = median_pkg::sort3(min_of_max, mid_of_mid, max_of_min);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            med <= '0;
        else
            med <= fin_srt[2*W-1:W];
    end

    // Border masking upstream must keep unwritten line buffer data out
    a_med_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(med));

endmodule

//--- design/median_filter_top.sv
`timescale 1ns/10ps

module median_filter_top #(
    parameter int IMG_HDISP = 1280,
    parameter int IMG_VDISP = 720
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,           // Change only while pre_vs is low
    input  logic             pre_vs,
    input  logic             pre_de,
    input  median_pkg::pix_t pre_data,
    output logic             post_vs,
    output logic             post_de,
    output median_pkg::pix_t post_data
);

    localparam int W = median_pkg::CH_W;

    logic             win_vs;
    logic             win_de;
    median_pkg::pix_t p11;
    median_pkg::pix_t p12;
    median_pkg::pix_t p13;
    median_pkg::pix_t p21;
    median_pkg::pix_t p22;
    median_pkg::pix_t p23;
    median_pkg::pix_t p31;
    median_pkg::pix_t p32;
    median_pkg::pix_t p33;
    median_pkg::pix_t med_data;

    window_gen #(
        .IMG_HDISP (IMG_HDISP),
        .IMG_VDISP (IMG_VDISP)
    ) u_win (
        .clk      (clk),
        .rst_n    (rst_n),
        .pre_vs   (pre_vs),
        .pre_de   (pre_de),
        .pre_data (pre_data),
        .win_vs   (win_vs),
        .win_de   (win_de),
        .p11      (p11),
        .p12      (p12),
        .p13      (p13),
        .p21      (p21),
        .p22      (p22),
        .p23      (p23),
        .p31      (p31),
        .p32      (p32),
        .p33      (p33)
    );

    // ------------------------------------------------------------------------
    // One median network per colour channel, blue at index 0
    // ------------------------------------------------------------------------
    for (genvar ch = 0; ch < median_pkg::NUM_CH; ch++) begin : g_chan
        median3x3 u_med (
            .clk   (clk),
            .rst_n (rst_n),
            .p11   (p11[ch*W +: W]),
            .p12   (p12[ch*W +: W]),
            .p13   (p13[ch*W +: W]),
            .p21   (p21[ch*W +: W]),
            .p22   (p22[ch*W +: W]),
            .p23   (p23[ch*W +: W]),
            .p31   (p31[ch*W +: W]),
            .p32   (p32[ch*W +: W]),
            .p33   (p33[ch*W +: W]),
            .med   (med_data[ch*W +: W])
        );
    end

    video_align u_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .pre_vs    (pre_vs),
        .pre_de    (pre_de),
        .pre_data  (pre_data),
        .win_vs    (win_vs),
        .win_de    (win_de),
        .med_data  (med_data),
        .post_vs   (post_vs),
        .post_de   (post_de),
        .post_data (post_data)
    );

endmodule

//--- design/median_pkg.sv
package median_pkg;

    // ------------------------------------------------------------------------
    // Pixel format
    // ------------------------------------------------------------------------
    localparam int CH_W   = 8;             // Bits per colour channel
    localparam int NUM_CH = 3;
    localparam int PIX_W  = CH_W * NUM_CH;

    typedef logic [CH_W-1:0]  chan_t;
    typedef logic [PIX_W-1:0] pix_t;       // Red in [23:16], blue in [7:0]

    // Pipeline depths
    localparam int WIN_LAT   = 1;          // Input to window taps
    localparam int MED_LAT   = 3;          // Window taps to median
    localparam int ALIGN_LAT = WIN_LAT + MED_LAT;

    // ------------------------------------------------------------------------
    // Three-value sorter, result packed as {max, mid, min}
    // ------------------------------------------------------------------------
    function automatic logic [3*CH_W-1:0] sort3(input chan_t a, input chan_t b,
                                                input chan_t c);
        chan_t hi;
        chan_t lo;
        chan_t mx;
        chan_t md;
        chan_t mn;
        hi = (a > b) ? a : b;
        lo = (a > b) ? b : a;
        mx = (hi > c) ? hi : c;
        mn = (lo < c) ? lo : c;
        // Middle is c unless it lies outside [lo, hi]
        if (c > hi)
            md = hi;
        else if (c < lo)
            md = lo;
        else
            md = c;
        return {mx, md, mn};
    endfunction

endpackage

//--- design/video_align.sv
`timescale 1ns/10ps

module video_align (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,           // Low selects the raw stream
    input  logic             pre_vs,
    input  logic             pre_de,
    input  median_pkg::pix_t pre_data,
    input  logic             win_vs,       // Controls at the window taps
    input  logic             win_de,
    input  median_pkg::pix_t med_data,     // Median network output
    output logic             post_vs,
    output logic             post_de,
    output median_pkg::pix_t post_data
);

    localparam int D = median_pkg::MED_LAT;

    logic [D-1:0] vs_dly;
    logic [D-1:0] de_dly;

    // ------------------------------------------------------------------------
    // Control delay line, matches the median network depth
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_dly <= '0;
            de_dly <= '0;
        end else begin
            vs_dly <= {vs_dly[D-2:0], win_vs};
            de_dly <= {de_dly[D-2:0], win_de};
        end
    end

    // Bypass is purely combinational
    assign post_vs   = en ? vs_dly[D-1] : pre_vs;
    assign post_de   = en ? de_dly[D-1] : pre_de;
    assign post_data = en ? med_data : pre_data;

    // Filtered stream keeps every active pixel inside the frame
    a_de_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (en && post_de) |-> post_vs);

endmodule

//--- design/window_gen.sv
`timescale 1ns/10ps

module window_gen #(
    parameter int IMG_HDISP = 1280,
    parameter int IMG_VDISP = 720
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pre_vs,       // High for the whole active frame
    input  logic             pre_de,
    input  median_pkg::pix_t pre_data,
    output logic             win_vs,
    output logic             win_de,
    output median_pkg::pix_t p11,          // Row 1 is the oldest line
    output median_pkg::pix_t p12,
    output median_pkg::pix_t p13,
    output median_pkg::pix_t p21,
    output median_pkg::pix_t p22,
    output median_pkg::pix_t p23,
    output median_pkg::pix_t p31,
    output median_pkg::pix_t p32,
    output median_pkg::pix_t p33           // Current pixel
);

    localparam int CW = $clog2(IMG_HDISP + 1);
    localparam int RW = $clog2(IMG_VDISP + 1);
    localparam int AW = $clog2(IMG_HDISP);

    logic [CW-1:0] col_cnt;                // Pixels seen in this line
    logic [RW-1:0] row_cnt;                // Lines finished in this frame
    logic [RW-1:0] row_cur;
    logic [AW-1:0] addr;
    logic          vs_rise;
    logic          line_end;
    logic          col_ok1;                // Column x-1 exists
    logic          col_ok2;                // Column x-2 exists
    logic          row_ok1;
    logic          row_ok2;

    median_pkg::pix_t line1 [IMG_HDISP];   // Line y-1
    median_pkg::pix_t line2 [IMG_HDISP];   // Line y-2
    median_pkg::pix_t tap   [1:3][1:3];    // [row][col]

    assign vs_rise  = pre_vs && !win_vs;
    assign line_end = win_de && !pre_de;
    assign row_cur  = vs_rise ? '0 : row_cnt;  // A new frame starts at row 0 at once
    assign addr     = col_cnt[AW-1:0];

    // ------------------------------------------------------------------------
    // Raster position
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_vs  <= 1'b0;
            win_de  <= 1'b0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else begin
            win_vs  <= pre_vs;
            win_de  <= pre_de;
            col_cnt <= pre_de ? col_cnt + 1'b1 : '0;
            if (vs_rise)
                row_cnt <= '0;
            else if (line_end)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    // Two line buffers, read before write at the same column
    always_ff @(posedge clk) begin
        if (pre_de) begin
            line1[addr] <= pre_data;
            line2[addr] <= line1[addr];
        end
    end

    // ------------------------------------------------------------------------
    // Column shift registers and border flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 1; r <= 3; r++) begin
                for (int c = 1; c <= 3; c++) begin
                    tap[r][c] <= '0;
                end
            end
            col_ok1 <= 1'b0;
            col_ok2 <= 1'b0;
            row_ok1 <= 1'b0;
            row_ok2 <= 1'b0;
        end else if (pre_de) begin
            for (int r = 1; r <= 3; r++) begin
                tap[r][1] <= tap[r][2];
                tap[r][2] <= tap[r][3];
            end
            tap[1][3] <= line2[addr];
            tap[2][3] <= line1[addr];
            tap[3][3] <= pre_data;
            col_ok1   <= (col_cnt != '0);
            col_ok2   <= (col_cnt > CW'(1));
            row_ok1   <= (row_cur != '0);
            row_ok2   <= (row_cur > RW'(1));
        end
    end

    // Positions above or left of the frame read as zero
    assign p11 = (row_ok2 && col_ok2) ? tap[1][1] : '0;
    assign p12 = (row_ok2 && col_ok1) ? tap[1][2] : '0;
    assign p13 = row_ok2 ? tap[1][3] : '0;
    assign p21 = (row_ok1 && col_ok2) ? tap[2][1] : '0;
    assign p22 = (row_ok1 && col_ok1) ? tap[2][2] : '0;
    assign p23 = row_ok1 ? tap[2][3] : '0;
    assign p31 = col_ok2 ? tap[3][1] : '0;
    assign p32 = col_ok1 ? tap[3][2] : '0;
    assign p33 = tap[3][3];

    // Stream must fit the configured frame size
    a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
        pre_de |-> col_cnt < IMG_HDISP);
    a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
        pre_de |-> row_cur < IMG_VDISP);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the median filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_median_filter \
    -Mdir obj_dir -o sim_median > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_median > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    echo "Test passed"
    exit 0
else
    echo "Test failed"
    exit 1
fi

//--- include/median_ref.svh
`ifndef MEDIAN_REF_SVH
`define MEDIAN_REF_SVH

median_pkg::pix_t frame [IMG_VDISP][IMG_HDISP];     // Current frame, [row][column]

// Fresh store at every frame start
function automatic void clear_frame();
    for (int y = 0; y < IMG_VDISP; y++) begin
        for (int x = 0; x < IMG_HDISP; x++) begin
            frame[y][x] = '0;
        end
    end
endfunction

function automatic void store_pixel(int x, int y, median_pkg::pix_t pix);
    frame[y][x] = pix;
endfunction

// Negative positions read as zero
function automatic median_pkg::chan_t window_sample(int x, int y, int ch);
    if (x < 0 || y < 0)
        return '0;
    return frame[y][x][ch*median_pkg::CH_W +: median_pkg::CH_W];
endfunction

// Median over rows y-2..y and columns x-2..x
function automatic median_pkg::chan_t chan_median(int x, int y, int ch);
    median_pkg::chan_t vals [9];
    median_pkg::chan_t v;
    int                n;
    int                k;
    n = 0;
    for (int dy = -2; dy <= 0; dy++) begin
        for (int dx = -2; dx <= 0; dx++) begin
            v = window_sample(x + dx, y + dy, ch);
            k = n;
            while (k > 0 && vals[k-1] > v) begin       // Insertion sort, ascending
                vals[k] = vals[k-1];
                k--;
            end
            vals[k] = v;
            n++;
        end
    end
    return vals[4];
endfunction

function automatic median_pkg::pix_t expected_pixel(int x, int y);
    median_pkg::pix_t pix;
    for (int ch = 0; ch < median_pkg::NUM_CH; ch++) begin
        pix[ch*median_pkg::CH_W +: median_pkg::CH_W] = chan_median(x, y, ch);
    end
    return pix;
endfunction

`endif

//--- verification/tb_median_filter.sv
`timescale 1ns/10ps

module tb_median_filter;

    localparam int IMG_HDISP = 8;
    localparam int IMG_VDISP = 6;
    localparam int ALIGN_LAT = median_pkg::ALIGN_LAT;
    localparam int PIX_W     = median_pkg::PIX_W;
    localparam int RST_CYC   = 10;
    localparam int MAX_GAP   = 6;                  // Longest blanking between lines
    localparam int NUM_FRAME = 3;

    // One frame is every line plus its worst gap, plus frame blanking
    localparam int FRAME_CYC   = IMG_VDISP * (IMG_HDISP + MAX_GAP) + 12;
    localparam int TIMEOUT_CYC = 5 * (RST_CYC + NUM_FRAME * FRAME_CYC + 10);

    logic             clk;
    logic             rst_n;
    logic             en;
    logic             pre_vs;
    logic             pre_de;
    median_pkg::pix_t pre_data;
    logic             post_vs;
    logic             post_de;
    median_pkg::pix_t post_data;

    integer seed = 34;
    int     cyc  = 0;
    int     col  = 0;
    int     row  = 0;
    logic   vs_prev = 1'b0;
    logic   de_prev = 1'b0;
    logic [ALIGN_LAT-1:0] vs_hist = '0;            // [0] is the previous cycle
    logic [ALIGN_LAT-1:0] de_hist = '0;

    int               due_q [$];                   // Cycle each filtered pixel is due
    median_pkg::pix_t exp_q [$];

    // Reference frame store and median rule
    `include "median_ref.svh"

    median_filter_top #(
        .IMG_HDISP (IMG_HDISP),
        .IMG_VDISP (IMG_VDISP)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .pre_vs    (pre_vs),
        .pre_de    (pre_de),
        .pre_data  (pre_data),
        .post_vs   (post_vs),
        .post_de   (post_de),
        .post_data (post_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("ERR at %0t ns: %s is %h, expected %h", $time, name, got, want);
        $display(">>> FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s (at %0t ns)", why, $time);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    // Rows 2 to 4 vary in a single channel only
    task automatic draw_pixel(input int line, output median_pkg::pix_t pix);
        logic [31:0] rnd;
        rnd = $random(seed);
        case (line)
            2:       pix = {rnd[7:0], 8'h5a, 8'h5a};
            3:       pix = {8'h5a, rnd[7:0], 8'h5a};
            4:       pix = {8'h5a, 8'h5a, rnd[7:0]};
            default: pix = rnd[PIX_W-1:0];
        endcase
    endtask

    task automatic send_line(input int line);
        logic [31:0] rnd;
        int          gap;
        for (int x = 0; x < IMG_HDISP; x++) begin
            @(negedge clk);
            pre_de = 1'b1;
            draw_pixel(line, pre_data);
        end
        rnd = $random(seed);
        gap = 1 + int'(rnd % MAX_GAP);
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            pre_de   = 1'b0;
            pre_data = '0;
        end
    endtask

    task automatic send_frame(input logic filt);
        @(negedge clk);
        en = filt;                                 // vs is low here
        @(negedge clk);
        pre_vs = 1'b1;
        for (int y = 0; y < IMG_VDISP; y++) begin
            send_line(y);
        end
        pre_vs = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Checks on values sampled at the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin : check_outputs
        if (cyc >= TIMEOUT_CYC) begin
            abort_run("Simulation did not finish within the cycle limit");
        end else begin
            if (cyc > 0 && !rst_n) begin
                assert (post_vs == 1'b0) else report_mismatch("post_vs", post_vs, 0);
                assert (post_de == 1'b0) else report_mismatch("post_de", post_de, 0);
            end else if (cyc > 0 && !en) begin    // Bypass
                assert (post_vs == pre_vs) else report_mismatch("post_vs", post_vs, pre_vs);
                assert (post_de == pre_de) else report_mismatch("post_de", post_de, pre_de);
                assert (post_data == pre_data)
                    else report_mismatch("post_data", post_data, pre_data);
            end else if (cyc > 0) begin
                assert (post_vs == vs_hist[ALIGN_LAT-1])
                    else report_mismatch("post_vs", post_vs, vs_hist[ALIGN_LAT-1]);
                assert (post_de == de_hist[ALIGN_LAT-1])
                    else report_mismatch("post_de", post_de, de_hist[ALIGN_LAT-1]);
                if (post_de && due_q.size() == 0) begin
                    abort_run("Filtered pixel appeared while none was expected");
                end else if (post_de) begin
                    assert (due_q[0] == cyc)
                        else abort_run("Filtered pixel arrived in the wrong cycle");
                    assert (post_data == exp_q[0])
                        else report_mismatch("post_data", post_data, exp_q[0]);
                    void'(due_q.pop_front());
                    void'(exp_q.pop_front());
                end
            end

            // Raster position of the sampled input
            if (pre_vs && !vs_prev) begin
                clear_frame();
                col = 0;
                row = 0;
            end
            if (pre_de) begin
                store_pixel(col, row, pre_data);
                if (en && rst_n) begin
                    due_q.push_back(cyc + ALIGN_LAT);
                    exp_q.push_back(expected_pixel(col, row));
                end
                col++;
            end else if (de_prev) begin
                col = 0;
                row++;
            end
            vs_prev = pre_vs;
            de_prev = pre_de;
            vs_hist = {vs_hist[ALIGN_LAT-2:0], pre_vs};
            de_hist = {de_hist[ALIGN_LAT-2:0], pre_de};
            cyc++;
        end
    end

    initial begin
        rst_n    = 1'b0;
        en       = 1'b1;
        pre_vs   = 1'b0;
        pre_de   = 1'b0;
        pre_data = '0;
        clear_frame();
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        send_frame(1'b0);                          // Raw pass-through
        send_frame(1'b1);
        send_frame(1'b1);                          // Restart must pad with zeros again
        repeat (ALIGN_LAT + 2) @(negedge clk);

        if (due_q.size() != 0) begin
            $display("%0d filtered pixels never appeared at the output", due_q.size());
            $display(">>> FAIL");
            $fatal(1, "missing output");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+include
design/median_pkg.sv
design/window_gen.sv
design/median3x3.sv
design/video_align.sv
design/median_filter_top.sv
verification/tb_median_filter.sv
